// File: design/rammodel_backend.sv
module rammodel_backend (
    input  logic                 target_clk,
    input  logic                 target_rst,

    input  logic                 req_valid,
    output logic                 req_ready,
    input  rammodel_pkg::axi_a_t req,
    input  logic                 wd_valid,
    output logic                 wd_ready,
    input  rammodel_pkg::axi_w_t wd,

    output logic                 b_valid,
    output rammodel_pkg::axi_b_t b,
    output logic                 r_valid,
    output rammodel_pkg::axi_r_t r
);

    import rammodel_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } seq_state_t;

    axi_a_t                     queue_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [QUEUE_CNT_WIDTH-1:0] q_count;
    logic                       push;
    logic                       pop;
    axi_a_t                     head;

    seq_state_t                 state;
    logic [ID_WIDTH-1:0]        cur_id;
    logic [MEM_ADDR_WIDTH-1:0]  cur_word;    // Read address stage
    logic [LEN_WIDTH-1:0]       beats_left;
    logic                       last_beat;
    logic                       w_fire;

    logic [DATA_WIDTH-1:0]      mem [MEM_WORDS];

    assign req_ready = q_count != QUEUE_CNT_WIDTH'(QUEUE_DEPTH);
    assign push = req_valid && req_ready;
    assign head = queue_mem[rd_ptr];
    assign pop = (state == ST_IDLE) && (q_count != '0);

    always_ff @(posedge target_clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge target_clk) begin
        if (target_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + QUEUE_PTR_WIDTH'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + QUEUE_PTR_WIDTH'(1);
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + QUEUE_CNT_WIDTH'(1);
                2'b01:   q_count <= q_count - QUEUE_CNT_WIDTH'(1);
                default: q_count <= q_count;
            endcase
        end
    end

    assign wd_ready = state == ST_WRITE;  // W stalls unless head is a write
    assign w_fire = wd_valid && wd_ready;
    assign last_beat = beats_left == '0;

    always_ff @(posedge target_clk) begin
        if (target_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        state <= head.write ? ST_WRITE : ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (w_fire && last_beat) begin
                        state <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (last_beat) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // INCR stepping, one word per beat
    always_ff @(posedge target_clk) begin
        if (pop) begin
            cur_id <= head.id;
            cur_word <= MEM_ADDR_WIDTH'(head.addr >> SIZE_FULL);  // Wraps at MEM_WORDS
            beats_left <= head.len;
        end else if (w_fire || state == ST_READ) begin
            cur_word <= cur_word + MEM_ADDR_WIDTH'(1);
            beats_left <= beats_left - LEN_WIDTH'(1);
        end
    end

    always_ff @(posedge target_clk) begin
        if (w_fire) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (wd.strb[i]) begin
                    mem[cur_word][i*8 +: 8] <= wd.data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge target_clk) begin
        if (target_rst) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            b_valid <= w_fire && last_beat;  // One cycle after the last W beat
            r_valid <= state == ST_READ;
        end
    end

    // Response payloads
    always_ff @(posedge target_clk) begin
        if (w_fire && last_beat) begin
            b <= '{id: cur_id, resp: RESP_OKAY};
        end
        if (state == ST_READ) begin
            r <= '{id: cur_id, data: mem[cur_word], resp: RESP_OKAY, last: last_beat};
        end
    end

endmodule

// File: design/rammodel_pkg.sv
package rammodel_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int ID_WIDTH = 4;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int LEN_WIDTH = 8;

    localparam int MAX_INFLIGHT = 8;
    localparam int INFLIGHT_CNT_WIDTH = $clog2(MAX_INFLIGHT + 1);

    localparam int MEM_WORDS = 256;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_WORDS);

    localparam int QUEUE_DEPTH = 16;  // Deeper than MAX_INFLIGHT
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    localparam logic [2:0] SIZE_FULL = 3'($clog2(STRB_WIDTH));  // Full-width beat
    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_aw_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_ar_t;

    // Merged AW/AR request as seen by the backend
    typedef struct packed {
        logic                  write;
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_a_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

endpackage

// File: design/rammodel_top.sv
module rammodel_top (
    input  logic                  target_clk,
    input  logic                  target_rst,

    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  rammodel_pkg::axi_aw_t aw,

    input  logic                  w_valid,
    output logic                  w_ready,
    input  rammodel_pkg::axi_w_t  w,

    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  rammodel_pkg::axi_ar_t ar,

    output logic                  b_valid,
    output rammodel_pkg::axi_b_t  b,

    output logic                  r_valid,
    output rammodel_pkg::axi_r_t  r
);

    import rammodel_pkg::*;

    logic   req_valid;
    logic   req_ready;
    axi_a_t req;
    logic   wd_valid;
    logic   wd_ready;
    axi_w_t wd;

    rammodel_tracker i_tracker (
        .target_clk (target_clk),
        .target_rst (target_rst),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw         (aw),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w          (w),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .wd_valid   (wd_valid),
        .wd_ready   (wd_ready),
        .wd         (wd),
        .b_valid    (b_valid),
        .r_valid    (r_valid),
        .r_last     (r.last)    // Final R beat closes a read
    );

    rammodel_backend i_backend (
        .target_clk (target_clk),
        .target_rst (target_rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .wd_valid   (wd_valid),
        .wd_ready   (wd_ready),
        .wd         (wd),
        .b_valid    (b_valid),
        .b          (b),
        .r_valid    (r_valid),
        .r          (r)
    );

endmodule

// File: design/rammodel_tracker.sv
module rammodel_tracker (
    input  logic                  target_clk,
    input  logic                  target_rst,

    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  rammodel_pkg::axi_aw_t aw,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  rammodel_pkg::axi_w_t  w,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  rammodel_pkg::axi_ar_t ar,

    output logic                  req_valid,
    input  logic                  req_ready,
    output rammodel_pkg::axi_a_t  req,
    output logic                  wd_valid,
    input  logic                  wd_ready,
    output rammodel_pkg::axi_w_t  wd,

    input  logic                  b_valid,
    input  logic                  r_valid,
    input  logic                  r_last
);

    import rammodel_pkg::*;

    axi_a_t [1:0]                  arb_s_data;
    logic   [1:0]                  arb_s_ready;
    logic                          arb_valid;
    logic                          arb_ready;
    axi_a_t                        arb_data;

    logic [INFLIGHT_CNT_WIDTH-1:0] inflight_cnt;
    logic [INFLIGHT_CNT_WIDTH-1:0] inflight_next;
    logic                          inflight_full;
    logic [INFLIGHT_CNT_WIDTH-1:0] aw_cnt;
    logic [INFLIGHT_CNT_WIDTH-1:0] aw_next;
    logic                          aw_pending;

    // Source 0 is AW, source 1 is AR
    assign arb_s_data[0] = '{write: 1'b1, id: aw.id, addr: aw.addr, len: aw.len,
                             size: aw.size, burst: aw.burst};
    assign arb_s_data[1] = '{write: 1'b0, id: ar.id, addr: ar.addr, len: ar.len,
                             size: ar.size, burst: ar.burst};
    assign aw_ready = arb_s_ready[0];
    assign ar_ready = arb_s_ready[1];

    ready_valid_arb #(
        .NUM_SOURCES (2)
    ) i_arb (
        .target_clk (target_clk),
        .target_rst (target_rst),
        .s_valid    ({ar_valid, aw_valid}),
        .s_ready    (arb_s_ready),
        .s_data     (arb_s_data),
        .m_valid    (arb_valid),
        .m_ready    (arb_ready),
        .m_data     (arb_data)
    );

    always_comb begin
        inflight_next = inflight_cnt;
        if (req_valid && req_ready) begin
            inflight_next = inflight_next + INFLIGHT_CNT_WIDTH'(1);
        end
        if (b_valid) begin
            inflight_next = inflight_next - INFLIGHT_CNT_WIDTH'(1);
        end
        if (r_valid && r_last) begin
            inflight_next = inflight_next - INFLIGHT_CNT_WIDTH'(1);
        end
    end

    // AWs whose W burst is not yet complete
    always_comb begin
        aw_next = aw_cnt;
        if (aw_valid && aw_ready) begin
            aw_next = aw_next + INFLIGHT_CNT_WIDTH'(1);
        end
        if (w_valid && w_ready && w.last) begin
            aw_next = aw_next - INFLIGHT_CNT_WIDTH'(1);
        end
    end

    always_ff @(posedge target_clk) begin
        if (target_rst) begin
            inflight_cnt <= '0;
            aw_cnt <= '0;
        end else begin
            inflight_cnt <= inflight_next;
            aw_cnt <= aw_next;
        end
    end

    assign inflight_full = inflight_cnt == INFLIGHT_CNT_WIDTH'(MAX_INFLIGHT);
    assign aw_pending = aw_cnt != '0;

    assign req_valid = arb_valid && !inflight_full;
    assign arb_ready = req_ready && !inflight_full;
    assign req = arb_data;

    assign wd_valid = w_valid && aw_pending;  // No W ahead of its AW
    assign w_ready = wd_ready && aw_pending;
    assign wd = w;

endmodule

// File: design/ready_valid_arb.sv
module ready_valid_arb #(
    parameter int NUM_SOURCES = 2
) (
    input  logic                                    target_clk,
    input  logic                                    target_rst,
    input  logic [NUM_SOURCES-1:0]                  s_valid,
    output logic [NUM_SOURCES-1:0]                  s_ready,
    input  rammodel_pkg::axi_a_t [NUM_SOURCES-1:0]  s_data,
    output logic                                    m_valid,
    input  logic                                    m_ready,
    output rammodel_pkg::axi_a_t                    m_data
);

    localparam int SEL_WIDTH = (NUM_SOURCES > 1) ? $clog2(NUM_SOURCES) : 1;

    logic [SEL_WIDTH-1:0] last_sel;  // Most recently granted source
    logic [SEL_WIDTH-1:0] held_sel;
    logic                 held;      // Output stalled last cycle
    logic [SEL_WIDTH-1:0] rr_sel;
    logic [SEL_WIDTH-1:0] sel;

    always_comb begin : rr_search
        int   idx;
        logic found;
        found = 1'b0;
        rr_sel = last_sel;
        for (int k = 1; k <= NUM_SOURCES; k++) begin
            idx = (int'(last_sel) + k) % NUM_SOURCES;
            if (!found && s_valid[idx]) begin
                found = 1'b1;
                rr_sel = SEL_WIDTH'(idx);
            end
        end
    end

    assign sel = held ? held_sel : rr_sel;  // Keep payload stable while stalled
    assign m_valid = s_valid[sel];
    assign m_data = s_data[sel];

    always_comb begin
        for (int i = 0; i < NUM_SOURCES; i++) begin
            s_ready[i] = m_ready && s_valid[i] && (sel == SEL_WIDTH'(i));
        end
    end

    always_ff @(posedge target_clk) begin
        if (target_rst) begin
            last_sel <= SEL_WIDTH'(NUM_SOURCES - 1);  // Source 0 wins first
            held <= 1'b0;
        end else begin
            held <= m_valid && !m_ready;
            if (m_valid && m_ready) begin
                last_sel <= sel;
            end
        end
    end

    always_ff @(posedge target_clk) begin
        held_sel <= sel;
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert --timing -f vlog.f --top-module tb_rammodel -o tb_rammodel; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rammodel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic target_clk,
    output logic target_rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        target_clk = 1'b0;
        forever begin
            #2 target_clk = ~target_clk;  // 4 ns period
        end
    end

    initial begin
        target_rst = 1'b1;
        repeat (16) @(posedge target_clk);
        #1 target_rst = 1'b0;  // Released off the edge like the stimulus
    end

endmodule

// File: sim/tb_rammodel.sv
module tb_rammodel;

    timeunit 1ns;
    timeprecision 100ps;

    import rammodel_pkg::*;

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic                      write;
        logic [ID_WIDTH-1:0]       id;
        logic [LEN_WIDTH-1:0]      len;
        logic [MEM_ADDR_WIDTH-1:0] word;
    } exp_t;

    logic    target_clk;
    logic    target_rst;
    logic    aw_valid;
    logic    aw_ready;
    axi_aw_t aw;
    logic    w_valid;
    logic    w_ready;
    axi_w_t  w;
    logic    ar_valid;
    logic    ar_ready;
    axi_ar_t ar;
    logic    b_valid;
    axi_b_t  b;
    logic    r_valid;
    axi_r_t  r;

    logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
    exp_t    exp_q [$];     // Responses in acceptance order
    exp_t    wr_pend [$];   // Accepted AWs still taking W beats
    axi_aw_t wr_plan [$];
    axi_aw_t rd_plan [$];
    int      wbeat = 0;
    int      rbeat = 0;
    int      addr_hs = 0;
    int      done_cnt = 0;
    int      inflight = 0;
    int      aw_acc = 0;
    int      wlast_acc = 0;
    logic    aw_skipped = 1'b0;
    logic    ar_skipped = 1'b0;
    logic    full_strb = 1'b1;
    int      value_errs = 0;
    int      proto_errs = 0;
    int      timeouts = 0;

    tb_clock_gen i_clk (
        .target_clk (target_clk),
        .target_rst (target_rst)
    );

    rammodel_top i_dut (
        .target_clk (target_clk),
        .target_rst (target_rst),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw         (aw),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w          (w),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .b_valid    (b_valid),
        .b          (b),
        .r_valid    (r_valid),
        .r          (r)
    );

    function automatic logic [MEM_ADDR_WIDTH-1:0] word_of(input logic [ADDR_WIDTH-1:0] addr);
        return MEM_ADDR_WIDTH'((addr / 8) % MEM_WORDS);  // 8 bytes per full beat
    endfunction

    function automatic axi_aw_t make_req(input int word, input int len);
        axi_aw_t a;
        a.id = ID_WIDTH'($urandom);
        a.addr = (ADDR_WIDTH'($urandom) & 32'hFFFF_F800) | ADDR_WIDTH'(word * 8);
        a.len = LEN_WIDTH'(len);
        a.size = SIZE_FULL;
        a.burst = BURST_INCR;
        return a;
    endfunction

    function automatic logic ready_of(input int ch);
        case (ch)
            0: return aw_ready;
            1: return w_ready;
            default: return ar_ready;
        endcase
    endfunction

    task automatic show_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        value_errs++;
    endtask

    task automatic handshake(input int ch, input string what);
        int n;
        n = 0;
        @(posedge target_clk);
        while (!ready_of(ch) && n < TIMEOUT) begin
            @(posedge target_clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Timed out waiting for the %s handshake", what);
            timeouts++;
        end
        #1;
    endtask

    task automatic run_writes(input int lead);
        fork
            begin
                repeat (lead) @(posedge target_clk);  // W may lead its AW
                #1;
                foreach (wr_plan[i]) begin
                    aw = wr_plan[i];
                    aw_valid = 1'b1;
                    handshake(0, "AW");
                end
                aw_valid = 1'b0;
            end
            begin
                foreach (wr_plan[i]) begin
                    for (int k = 0; k <= int'(wr_plan[i].len); k++) begin
                        w.data = {$urandom, $urandom};
                        w.strb = full_strb ? '1 : STRB_WIDTH'($urandom);
                        w.last = k == int'(wr_plan[i].len);
                        w_valid = 1'b1;
                        handshake(1, "W");
                    end
                end
                w_valid = 1'b0;
            end
        join
        wr_plan.delete();
    endtask

    task automatic run_reads();
        foreach (rd_plan[i]) begin
            ar = axi_ar_t'(rd_plan[i]);
            ar_valid = 1'b1;
            handshake(2, "AR");
        end
        ar_valid = 1'b0;
        rd_plan.delete();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || wr_pend.size() != 0) && n < TIMEOUT) begin
            @(posedge target_clk);
            #1;
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Timed out waiting for outstanding responses to drain");
            timeouts++;
        end
    endtask

    // Scoreboard
    always @(posedge target_clk) begin
        exp_t                      e;
        logic [MEM_ADDR_WIDTH-1:0] wi;
        if (!target_rst) begin
            if (aw_valid && aw_ready) begin
                e = '{write: 1'b1, id: aw.id, len: aw.len, word: word_of(aw.addr)};
                exp_q.push_back(e);
                wr_pend.push_back(e);
                addr_hs++;
                aw_acc++;
                assert (!(ar_valid && ar_skipped)) else begin
                    $display("AR was passed over for two AW grants in a row");
                    proto_errs++;
                end
                ar_skipped = ar_valid;
                aw_skipped = 1'b0;
            end
            if (ar_valid && ar_ready) begin
                e = '{write: 1'b0, id: ar.id, len: ar.len, word: word_of(ar.addr)};
                exp_q.push_back(e);
                addr_hs++;
                assert (!(aw_valid && aw_skipped)) else begin
                    $display("AW was passed over for two AR grants in a row");
                    proto_errs++;
                end
                aw_skipped = aw_valid;
                ar_skipped = 1'b0;
            end
            if (w_valid && w_ready) begin
                if (wr_pend.size() == 0) begin
                    $display("A W beat was accepted with no write address pending");
                    proto_errs++;
                end else begin
                    wi = wr_pend[0].word + MEM_ADDR_WIDTH'(wbeat);
                    for (int i = 0; i < STRB_WIDTH; i++) begin
                        if (w.strb[i]) begin
                            ref_mem[wi][i*8 +: 8] = w.data[i*8 +: 8];
                        end
                    end
                    wbeat++;
                    if (w.last) begin
                        void'(wr_pend.pop_front());
                        wbeat = 0;
                        wlast_acc++;
                    end
                end
            end
            if (b_valid || r_valid) begin
                if (exp_q.size() == 0) begin
                    $display("A response arrived with nothing outstanding");
                    proto_errs++;
                end else begin
                    e = exp_q[0];
                    if (b_valid) begin
                        assert (e.write) else show_mismatch("b_valid", 1, 0);
                        assert (b.id == e.id) else show_mismatch("b.id", b.id, e.id);
                        assert (b.resp == RESP_OKAY) else show_mismatch("b.resp", b.resp, 0);
                        void'(exp_q.pop_front());
                        done_cnt++;
                    end else begin
                        wi = e.word + MEM_ADDR_WIDTH'(rbeat);
                        assert (!e.write) else show_mismatch("r_valid", 1, 0);
                        assert (r.id == e.id) else show_mismatch("r.id", r.id, e.id);
                        assert (r.resp == RESP_OKAY) else show_mismatch("r.resp", r.resp, 0);
                        assert (r.data === ref_mem[wi]) else begin
                            show_mismatch("r.data", r.data, ref_mem[wi]);
                        end
                        assert (r.last == (LEN_WIDTH'(rbeat) == e.len)) else begin
                            show_mismatch("r.last", r.last, LEN_WIDTH'(rbeat) == e.len);
                        end
                        rbeat++;
                        if (r.last) begin
                            void'(exp_q.pop_front());
                            rbeat = 0;
                            done_cnt++;
                        end
                    end
                end
            end
            inflight = addr_hs - done_cnt;
        end
    end

    ast_reset_quiet: assert property (@(posedge target_clk)
        (target_rst && $past(target_rst))
            |-> !aw_ready && !ar_ready && !w_ready && !b_valid && !r_valid)
        else begin
            $display("A ready or valid output was active during reset");
            proto_errs++;
        end

    ast_inflight_cap: assert property (@(posedge target_clk) inflight <= MAX_INFLIGHT)
        else begin
            $display("More than the allowed number of requests were in flight");
            proto_errs++;
        end

    ast_inflight_block: assert property (@(posedge target_clk)
        (inflight == MAX_INFLIGHT) |-> !aw_ready && !ar_ready)
        else begin
            $display("An address was accepted while the in-flight limit was reached");
            proto_errs++;
        end

    ast_w_gated: assert property (@(posedge target_clk) disable iff (target_rst)
        (w_valid && w_ready) |-> aw_acc > wlast_acc)
        else begin
            $display("A W beat was accepted ahead of its write address");
            proto_errs++;
        end

    ast_b_after_w: assert property (@(posedge target_clk) disable iff (target_rst)
        (w_valid && w_ready && w.last) |=> b_valid)
        else begin
            $display("No write response in the cycle after the last W beat");
            proto_errs++;
        end

    ast_b_cause: assert property (@(posedge target_clk) disable iff (target_rst)
        b_valid |-> $past(w_valid && w_ready && w.last))
        else begin
            $display("A write response appeared without a preceding last W beat");
            proto_errs++;
        end

    initial begin
        int n;
        void'($urandom(68));
        aw_valid = 1'b0;
        aw = '0;
        w_valid = 1'b0;
        w = '0;
        ar_valid = 1'b0;
        ar = '0;
        n = 0;
        @(posedge target_clk);
        while (target_rst !== 1'b0 && n < TIMEOUT) begin
            @(posedge target_clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("Timed out waiting for reset to be released");
            timeouts++;
        end
        @(posedge target_clk);
        assert (!aw_ready && !ar_ready && !w_ready && !b_valid && !r_valid) else begin
            $display("Outputs were not idle right after reset");
            proto_errs++;
        end
        #1;

        // Fill words 0 to 63 with whole beats while W leads the AW
        for (int i = 0; i < 8; i++) begin
            wr_plan.push_back(make_req(i * 8, 7));
        end
        run_writes(5);
        wait_idle();

        for (int i = 0; i < 12; i++) begin
            rd_plan.push_back(make_req($urandom_range(0, 56), $urandom_range(0, 7)));
        end
        run_reads();
        wait_idle();

        // Strobed writes racing reads over the same region
        full_strb = 1'b0;
        for (int i = 0; i < 24; i++) begin
            wr_plan.push_back(make_req($urandom_range(0, 56), $urandom_range(0, 7)));
            rd_plan.push_back(make_req($urandom_range(0, 56), $urandom_range(0, 7)));
        end
        fork
            run_writes(0);
            run_reads();
        join
        wait_idle();

        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errs, proto_errs, timeouts);
        if (value_errs + proto_errs + timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/rammodel_pkg.sv
design/ready_valid_arb.sv
design/rammodel_tracker.sv
design/rammodel_backend.sv
design/rammodel_top.sv
sim/tb_clock_gen.sv
sim/tb_rammodel.sv
